// File: design/memPkg.sv
`default_nettype none

package memPkg;

    localparam int AddrWidth = 32;
    localparam int ByteWidth = 8;
    localparam int WordWidth = 32;
    localparam int WordBytes = 4;

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [ByteWidth-1:0] byte_t;
    typedef logic [WordWidth-1:0] word_t;

    // bytes per data access
    typedef logic [2:0] len_t;

    // ram bus as driven by one peer
    typedef struct packed {
        logic  write;
        addr_t addr;
        byte_t wdata;
    } memReq_t;

    // load or store command from the cpu side
    typedef struct packed {
        logic  write;
        len_t  len;
        addr_t addr;
        word_t wdata;
    } dataReq_t;

    typedef enum logic [1:0] {
        GrantNone,
        GrantData,
        GrantFetch
    } grant_t;

endpackage

`default_nettype wire

// File: design/memArbiter.sv
`default_nettype none

module memArbiter import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_rdy,
    input  logic    i_fetchReq,
    input  logic    i_dataReq,
    input  logic    i_fetchDone,
    input  logic    i_dataDone,
    input  memReq_t i_fetchBus,
    input  memReq_t i_dataBus,
    output logic    o_fetchGrant,
    output logic    o_dataGrant,
    output memReq_t o_memBus
);

    grant_t grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= GrantNone;
        end else if (i_rdy) begin
            case (grant)
                GrantNone: begin
                    // data side wins a tie
                    if (i_dataReq) begin
                        grant <= GrantData;
                    end else if (i_fetchReq) begin
                        grant <= GrantFetch;
                    end
                end
                GrantData: begin
                    if (i_dataDone) begin
                        grant <= GrantNone;
                    end
                end
                GrantFetch: begin
                    if (i_fetchDone) begin
                        grant <= GrantNone;
                    end
                end
                default: begin
                    grant <= GrantNone;
                end
            endcase
        end
    end

    assign o_fetchGrant = (grant == GrantFetch);
    assign o_dataGrant  = (grant == GrantData);

    always_comb begin
        case (grant)
            GrantData:  o_memBus = i_dataBus;
            GrantFetch: o_memBus = i_fetchBus;
            default:    o_memBus = '0;
        endcase
        // address stays put while paused so the pending byte is kept
        if (!i_rdy) begin
            o_memBus.write = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/instFetchPort.sv
`default_nettype none

module instFetchPort import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_rdy,
    input  logic    i_grant,
    input  addr_t   i_addr,
    input  byte_t   i_memRdata,
    output memReq_t o_memBus,
    output logic    o_done,
    output word_t   o_inst
);

    len_t cnt;
    len_t offset;
    logic step;
    logic lastStep;

    // bytes 0 to 2 of the instruction
    logic [WordWidth-ByteWidth-1:0] asm;

    assign step     = i_grant && i_rdy;
    assign lastStep = (cnt == len_t'(WordBytes));

    // when paused keep showing the address whose byte is still due
    always_comb begin
        if (!i_rdy && cnt != '0) begin
            offset = cnt - len_t'(1);
        end else begin
            offset = cnt;
        end
    end

    assign o_memBus = '{
        write: 1'b0,
        addr:  i_addr + AddrWidth'(offset),
        wdata: '0
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (step) begin
            cnt <= lastStep ? '0 : cnt + len_t'(1);
        end
    end

    // shift in from the top, first byte ends up lowest
    always_ff @(posedge clk) begin
        if (step && cnt != '0 && !lastStep) begin
            asm <= {i_memRdata, asm[WordWidth-ByteWidth-1:ByteWidth]};
        end
    end

    assign o_done = step && lastStep;

    // top byte comes straight off the ram
    assign o_inst = {i_memRdata, asm};

endmodule

`default_nettype wire

// File: design/dataPort.sv
`default_nettype none

module dataPort import memPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_rdy,
    input  logic     i_grant,
    input  dataReq_t i_req,
    input  byte_t    i_memRdata,
    output memReq_t  o_memBus,
    output logic     o_done,
    output word_t    o_rdata
);

    len_t cnt;
    len_t offset;
    len_t lastCnt;
    logic step;
    logic lastStep;
    logic [1:0] capIdx;
    logic [1:0] topIdx;

    // load bytes below the last one
    logic [WordBytes-2:0][ByteWidth-1:0] loadBytes;
    logic [WordBytes-1:0][ByteWidth-1:0] storeBytes;

    assign step = i_grant && i_rdy;

    // stores finish with the last write, loads one cycle later
    assign lastCnt  = i_req.write ? i_req.len - len_t'(1) : i_req.len;
    assign lastStep = (cnt == lastCnt);

    assign capIdx = 2'(cnt - len_t'(1));
    assign topIdx = 2'(i_req.len - len_t'(1));

    always_comb begin
        if (!i_rdy && cnt != '0) begin
            offset = cnt - len_t'(1);
        end else begin
            offset = cnt;
        end
    end

    assign storeBytes = i_req.wdata;

    assign o_memBus = '{
        write: i_req.write,
        addr:  i_req.addr + AddrWidth'(offset),
        wdata: storeBytes[cnt[1:0]]
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (step) begin
            cnt <= lastStep ? '0 : cnt + len_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (step && !i_req.write && cnt != '0 && !lastStep) begin
            loadBytes[capIdx] <= i_memRdata;
        end
    end

    assign o_done = step && lastStep;

    // little endian, zero above the loaded length
    always_comb begin
        o_rdata = '0;
        for (int k = 0; k < WordBytes - 1; k++) begin
            if (k < int'(i_req.len) - 1) begin
                o_rdata[k*ByteWidth +: ByteWidth] = loadBytes[k];
            end
        end
        // last byte is taken off the read port directly
        o_rdata[topIdx*ByteWidth +: ByteWidth] = i_memRdata;
    end

endmodule

`default_nettype wire

// File: design/memCtrl.sv
`default_nettype none

module memCtrl import memPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_rdy,

    input  logic     i_fetchReq,
    input  addr_t    i_fetchAddr,
    output logic     o_fetchDone,
    output word_t    o_inst,

    input  logic     i_dataReq,
    input  dataReq_t i_dataCmd,
    output logic     o_dataDone,
    output word_t    o_loadData,

    input  byte_t    i_memRdata,
    output memReq_t  o_memBus
);

    memReq_t fetchBus;
    memReq_t dataBus;
    logic    fetchGrant;
    logic    dataGrant;

    memArbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_rdy        (i_rdy),
        .i_fetchReq   (i_fetchReq),
        .i_dataReq    (i_dataReq),
        .i_fetchDone  (o_fetchDone),
        .i_dataDone   (o_dataDone),
        .i_fetchBus   (fetchBus),
        .i_dataBus    (dataBus),
        .o_fetchGrant (fetchGrant),
        .o_dataGrant  (dataGrant),
        .o_memBus     (o_memBus)
    );

    instFetchPort u_fetch (
        .clk        (clk),
        .rst        (rst),
        .i_rdy      (i_rdy),
        .i_grant    (fetchGrant),
        .i_addr     (i_fetchAddr),
        .i_memRdata (i_memRdata),
        .o_memBus   (fetchBus),
        .o_done     (o_fetchDone),
        .o_inst     (o_inst)
    );

    dataPort u_data (
        .clk        (clk),
        .rst        (rst),
        .i_rdy      (i_rdy),
        .i_grant    (dataGrant),
        .i_req      (i_dataCmd),
        .i_memRdata (i_memRdata),
        .o_memBus   (dataBus),
        .o_done     (o_dataDone),
        .o_rdata    (o_loadData)
    );

endmodule

`default_nettype wire

// File: dv/memCtrl_asserts.sv
`default_nettype none

module memCtrlAsserts import memPkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    i_fetchGrant,
    input logic    i_dataGrant,
    input logic    i_fetchDone,
    input logic    i_dataDone,
    input memReq_t i_memBus
);

    timeunit 1ns;
    timeprecision 1ps;

    // one owner at a time and an idle cycle between owners
    grantsExclusive: assert property (@(posedge clk) disable iff (rst)
        !((i_fetchGrant || $past(i_fetchGrant)) && (i_dataGrant || $past(i_dataGrant))))
        else $error("grants overlap or pass between the peers without an idle cycle");

    // only the data port writes
    writeUnderDataGrant: assert property (@(posedge clk) disable iff (rst)
        i_memBus.write |-> i_dataGrant)
        else $error("RAM write seen without the data grant");

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        i_fetchDone |=> !i_fetchDone)
        else $error("fetch done held for more than one cycle");

    dataDonePulse: assert property (@(posedge clk) disable iff (rst)
        i_dataDone |=> !i_dataDone)
        else $error("data done held for more than one cycle");

    // first cycle out of reset is quiet
    quietAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> !(i_fetchDone || i_dataDone))
        else $error("done pulse in the first cycle after reset");

endmodule

`default_nettype wire

// File: dv/memCtrlTb.sv
`default_nettype none

module memCtrlTb import memPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod      = 8;
    localparam int ResetCycles    = 10;
    localparam int NumOps         = 300;
    localparam int NumGapOps      = 60;
    localparam int NumDirectedOps = 10;
    localparam int CyclesPerOp    = 20;
    localparam int TimeoutCycles  = (NumOps + NumGapOps + NumDirectedOps) * CyclesPerOp;

    logic     clk;
    logic     rst;
    logic     rdy;
    logic     rdyRandom;
    logic     fetchReq;
    addr_t    fetchAddr;
    logic     fetchDone;
    word_t    inst;
    logic     dataReq;
    dataReq_t dataCmd;
    logic     dataDone;
    word_t    loadData;
    byte_t    memRdata;
    memReq_t  memBus;

    byte_t       ram [0:255];
    byte_t       shadow [0:255];
    word_t       expFetch [$];
    word_t       expData [$];
    logic        dataIsLoad [$];
    logic [15:0] lfsr = 16'd43;
    logic [15:0] rdyLfsr = 16'd43;
    int          cycles = 0;
    int          fetchDoneCount = 0;
    int          dataDoneCount = 0;
    int          fetchDoneAt = 0;
    int          dataDoneAt = 0;

    memCtrl i_dut (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (rdy),
        .i_fetchReq  (fetchReq),
        .i_fetchAddr (fetchAddr),
        .o_fetchDone (fetchDone),
        .o_inst      (inst),
        .i_dataReq   (dataReq),
        .i_dataCmd   (dataCmd),
        .o_dataDone  (dataDone),
        .o_loadData  (loadData),
        .i_memRdata  (memRdata),
        .o_memBus    (memBus)
    );

    bind memArbiter memCtrlAsserts u_asserts (
        .clk          (clk),
        .rst          (rst),
        .i_fetchGrant (o_fetchGrant),
        .i_dataGrant  (o_dataGrant),
        .i_fetchDone  (i_fetchDone),
        .i_dataDone   (i_dataDone),
        .i_memBus     (o_memBus)
    );

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
        return v;
    endfunction

    function automatic logic rdyBit();
        logic b;
        b = rdyLfsr[0];
        rdyLfsr = lfsrNext(rdyLfsr);
        return b;
    endfunction

    // little endian from the shadow copy and zero above len
    function automatic word_t refRead(input addr_t base, input int len);
        word_t w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[k*ByteWidth +: ByteWidth] = shadow[8'(base + addr_t'(k))];
        end
        return w;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // 256 byte ram with read data one cycle after the address
    initial begin
        logic [7:0] rdAddr;
        memRdata = '0;
        for (int a = 0; a < 256; a++) begin
            ram[8'(a)] = byte_t'(a * 37 + 11);
            shadow[8'(a)] = byte_t'(a * 37 + 11);
        end
        forever begin
            @(posedge clk);
            rdAddr = memBus.addr[7:0];
            if (memBus.write) begin
                assert (rdy) else reportFailure("RAM saw a write while ready was low");
                ram[rdAddr] = memBus.wdata;
            end
            #1;
            memRdata = ram[rdAddr];
        end
    end

    initial begin
        rdy = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            // low about a quarter of the cycles
            rdy = rdyRandom ? (rdyBit() | rdyBit()) : 1'b1;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > TimeoutCycles) begin
                reportFailure($sformatf("timeout, run not finished after %0d cycles", cycles));
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && fetchDone) begin
            assert (expFetch.size() > 0) else reportFailure("fetch done with no fetch pending");
            assert (inst === expFetch[0]) else reportFailure($sformatf(
                "Mismatch at %0t: o_inst got %08h expected %08h", $time, inst, expFetch[0]));
            expFetch.delete(0);
            fetchDoneCount++;
            fetchDoneAt = cycles;
        end
        if (!rst && dataDone) begin
            assert (dataIsLoad.size() > 0) else reportFailure("data done with no access pending");
            if (dataIsLoad[0]) begin
                assert (loadData === expData[0]) else reportFailure($sformatf(
                    "Mismatch at %0t: o_loadData got %08h expected %08h",
                    $time, loadData, expData[0]));
            end
            dataIsLoad.delete(0);
            expData.delete(0);
            dataDoneCount++;
            dataDoneAt = cycles;
        end
    end

    // raise the requests together and hold each until its done pulse
    task automatic doOps(input logic doFetch, input addr_t fAddr, input logic doData,
                         input dataReq_t cmd);
        int fTarget;
        int dTarget;
        fTarget = fetchDoneCount + (doFetch ? 1 : 0);
        dTarget = dataDoneCount + (doData ? 1 : 0);
        @(posedge clk);
        #1;
        // data goes first, so the shadow takes the store before the fetch is predicted
        if (doData) begin
            if (cmd.write) begin
                for (int k = 0; k < int'(cmd.len); k++) begin
                    shadow[8'(cmd.addr + addr_t'(k))] = cmd.wdata[k*ByteWidth +: ByteWidth];
                end
            end
            expData.push_back(refRead(cmd.addr, int'(cmd.len)));
            dataIsLoad.push_back(!cmd.write);
            dataCmd = cmd;
            dataReq = 1'b1;
        end
        if (doFetch) begin
            expFetch.push_back(refRead(fAddr, WordBytes));
            fetchAddr = fAddr;
            fetchReq = 1'b1;
        end
        while (fetchReq || dataReq) begin
            @(posedge clk);
            #1;
            if (fetchReq && fetchDoneCount >= fTarget) begin
                fetchReq = 1'b0;
            end
            if (dataReq && dataDoneCount >= dTarget) begin
                dataReq = 1'b0;
            end
        end
        if (doFetch && doData) begin
            assert (dataDoneAt < fetchDoneAt)
                else reportFailure("fetch finished before the data access raised with it");
        end
    endtask

    task automatic randomOp();
        logic [2:0] sel;
        logic [1:0] lenSel;
        dataReq_t   cmd;
        sel = 3'(takeBits(3));
        lenSel = 2'(takeBits(2));
        cmd.write = sel[2];
        cmd.len = (lenSel == 2'd3) ? len_t'(4) : len_t'(1) << lenSel;
        cmd.addr = takeBits(8);
        cmd.wdata = takeBits(32);
        doOps(sel[0], takeBits(8), sel[1] || !sel[0], cmd);
    endtask

    task automatic checkRamImage();
        for (int a = 0; a < 256; a++) begin
            assert (ram[8'(a)] === shadow[8'(a)]) else reportFailure($sformatf(
                "Mismatch at %0t: ram[%0d] got %02h expected %02h",
                $time, a, ram[8'(a)], shadow[8'(a)]));
        end
    endtask

    initial begin
        dataReq_t cmd;
        rst = 1'b1;
        rdyRandom = 1'b0;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReq = 1'b0;
        dataCmd = '{write: 1'b0, len: len_t'(4), addr: '0, wdata: '0};
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;

        doOps(1'b1, 32'h10, 1'b0, dataCmd);

        // store then load back for each length
        for (int i = 0; i < 3; i++) begin
            cmd = '{write: 1'b1, len: len_t'(1 << i), addr: addr_t'(64 + 16 * i),
                    wdata: 32'hC3A5_7E19 ^ word_t'(i)};
            doOps(1'b0, '0, 1'b1, cmd);
            cmd.write = 1'b0;
            doOps(1'b0, '0, 1'b1, cmd);
        end
        checkRamImage();

        // both requests in the same cycle
        cmd = '{write: 1'b0, len: len_t'(4), addr: 32'h90, wdata: '0};
        doOps(1'b1, 32'h80, 1'b1, cmd);
        cmd = '{write: 1'b1, len: len_t'(2), addr: 32'h41, wdata: 32'h0000_BEEF};
        doOps(1'b1, 32'h40, 1'b1, cmd);

        rdyRandom = 1'b1;
        repeat (NumGapOps) randomOp();
        rdyRandom = 1'b0;
        repeat (NumOps) randomOp();
        checkRamImage();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
design/memPkg.sv
design/memArbiter.sv
design/instFetchPort.sv
design/dataPort.sv
design/memCtrl.sv
dv/memCtrl_asserts.sv
dv/memCtrlTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
result=$(verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module memCtrlTb -o memCtrlSim -f tb.f 2>&1 \
    && ./obj_dir/memCtrlSim 2>&1)
echo "$result"
echo "$result" | grep -qx "=== PASS ===" && exit 0 || exit 1
